/* switch_macros.svh */
/* Size constants of the four-port to one-port bus switch:
   port count, port index width, ID, address and data widths. */
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Port count and index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SW_PORTS 4 // Upstream requesters.
`define SW_SEL_WIDTH 2 // Bits that encode an upstream port index.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// The downstream ID is the port index stacked on this width.
`define SW_LOCAL_ID_WIDTH 4

`define SW_ADDR_WIDTH 16
`define SW_DATA_WIDTH 32

`endif

/* switch_pkg.sv */
/* Shared types of the bus switch: port index, ID, address and data
   vectors, and the round-robin arbiter FSM states. */
`include "switch_macros.svh"

package switch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Number of one upstream port.
  typedef logic [`SW_SEL_WIDTH-1:0] port_idx_t;

  // ID as a requester sees it.
  typedef logic [`SW_LOCAL_ID_WIDTH-1:0] local_id_t;

  // Downstream ID, port index in the upper bits.
  typedef logic [`SW_SEL_WIDTH+`SW_LOCAL_ID_WIDTH-1:0] bus_id_t;

  typedef logic [`SW_ADDR_WIDTH-1:0] addr_t;

  typedef logic [`SW_DATA_WIDTH-1:0] data_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbiter FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    ARB_IDLE, // Grant follows the request search.
    ARB_HOLD  // Grant frozen until acknowledged.
  } arb_state_t;

endpackage

/* switch_rr_arbiter.sv */
/* Round-robin arbiter with a rotating pointer, which keeps its grant
   until the granted request is acknowledged. */
`include "switch_macros.svh"

module switch_rr_arbiter
  import switch_pkg::*;
#(
  parameter int PORTS = `SW_PORTS
)(
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic [PORTS-1:0] i_request,
  input  logic             i_ack,
  output logic [PORTS-1:0] o_grant,
  output port_idx_t        o_grant_idx
);
  arb_state_t state;
  port_idx_t  pointer;
  port_idx_t  held_idx;
  port_idx_t  search_idx;
  port_idx_t  next_pointer;
  logic       search_hit;
  logic       grant_valid;

  // First request at or after the pointer, wrapping at PORTS.
  always_comb begin
    int lane;
    search_idx = '0;
    search_hit = 1'b0;
    for (int i = 0; i < PORTS; i++) begin
      lane = int'(pointer) + i;
      if (lane >= PORTS) begin
        lane = lane - PORTS;
      end
      if (!search_hit && i_request[lane]) begin
        search_hit = 1'b1;
        search_idx = port_idx_t'(lane);
      end
    end
  end

  always_comb begin
    if (state == ARB_HOLD) begin
      grant_valid = 1'b1;
      o_grant_idx = held_idx;
    end else begin
      grant_valid = search_hit;
      o_grant_idx = search_idx;
    end
  end

  always_comb begin
    for (int i = 0; i < PORTS; i++) begin
      o_grant[i] = grant_valid && (o_grant_idx == port_idx_t'(i));
    end
  end

  assign next_pointer = (o_grant_idx == port_idx_t'(PORTS - 1)) ? '0 : o_grant_idx + 1'b1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= ARB_IDLE;
      pointer <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (search_hit && i_ack) begin
            pointer <= next_pointer; // Accepted in the grant cycle.
          end else if (search_hit) begin
            state <= ARB_HOLD;
          end
        end
        ARB_HOLD: begin
          if (i_ack) begin
            state   <= ARB_IDLE;
            pointer <= next_pointer;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // Winner captured while idle, replayed in ARB_HOLD.
  always_ff @(posedge i_clk) begin
    if (state == ARB_IDLE) begin
      held_idx <= search_idx;
    end
  end

endmodule

/* switch_request_path.sv */
/* Request path of the switch: arbitrates the upstream command lanes,
   forwards the winner downstream and widens its ID by the port index. */
`include "switch_macros.svh"

module switch_request_path
  import switch_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_rst,

  // Upstream command lanes.
  input  logic [`SW_PORTS-1:0]      i_cmd_valid,
  input  local_id_t [`SW_PORTS-1:0] i_cmd_id,
  input  addr_t [`SW_PORTS-1:0]     i_cmd_addr,
  input  logic [`SW_PORTS-1:0]      i_cmd_write,
  input  data_t [`SW_PORTS-1:0]     i_cmd_data,
  output logic [`SW_PORTS-1:0]      o_cmd_accept,

  // Downstream command port.
  output logic                      o_m_cmd_valid,
  output bus_id_t                   o_m_cmd_id,
  output addr_t                     o_m_cmd_addr,
  output logic                      o_m_cmd_write,
  output data_t                     o_m_cmd_data,
  input  logic                      i_m_cmd_accept
);
  logic [`SW_PORTS-1:0] grant;
  port_idx_t            grant_idx;
  logic                 cmd_ack;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arbitration
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  switch_rr_arbiter #(
    .PORTS        (`SW_PORTS    )
  ) switch_rr_arbiter_inst (
    .i_clk        (i_clk        ),
    .i_rst        (i_rst        ),
    .i_request    (i_cmd_valid  ),
    .i_ack        (cmd_ack      ),
    .o_grant      (grant        ),
    .o_grant_idx  (grant_idx    )
  );

  // The pointer moves only on a real downstream transfer.
  assign cmd_ack = o_m_cmd_valid && i_m_cmd_accept;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command forwarding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign o_m_cmd_valid = |grant;

  always_comb begin
    o_m_cmd_id    = {grant_idx, i_cmd_id[grant_idx]}; // Port index above the local ID.
    o_m_cmd_addr  = i_cmd_addr[grant_idx];
    o_m_cmd_write = i_cmd_write[grant_idx];
    o_m_cmd_data  = i_cmd_data[grant_idx];
  end

  // Only the granted lane sees the downstream accept.
  always_comb begin
    for (int i = 0; i < `SW_PORTS; i++) begin
      o_cmd_accept[i] = grant[i] && i_m_cmd_accept;
    end
  end

endmodule

/* switch_response_path.sv */
/* Response path of the switch: decodes the port index from the
   downstream response ID and steers the response to that port. */
`include "switch_macros.svh"

module switch_response_path
  import switch_pkg::*;
(
  // Downstream response port.
  input  logic                 i_m_res_valid,
  input  bus_id_t              i_m_res_id,
  input  data_t                i_m_res_data,
  output logic                 o_m_res_accept,

  // Upstream response lanes, ID and data shared by all.
  output logic [`SW_PORTS-1:0] o_res_valid,
  output local_id_t            o_res_id,
  output data_t                o_res_data,
  input  logic [`SW_PORTS-1:0] i_res_accept
);
  localparam int BUS_ID_WIDTH = $bits(bus_id_t);

  port_idx_t res_port;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ID decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign res_port = i_m_res_id[BUS_ID_WIDTH-1-:`SW_SEL_WIDTH]; // Inserted by the request path.

  always_comb begin
    for (int p = 0; p < `SW_PORTS; p++) begin
      o_res_valid[p] = i_m_res_valid && (res_port == port_idx_t'(p));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Payload and back-pressure
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign o_res_id   = i_m_res_id[`SW_LOCAL_ID_WIDTH-1:0]; // Index bits stripped.
  assign o_res_data = i_m_res_data;

  assign o_m_res_accept = i_res_accept[res_port];

endmodule

/* switch_m_to_1.sv */
/* Four-port to one-port bus switch, joining the arbitrating request
   path and the ID-routed response path. */
`include "switch_macros.svh"

module switch_m_to_1
  import switch_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_rst,

  // Upstream command lanes.
  input  logic [`SW_PORTS-1:0]      i_cmd_valid,
  input  local_id_t [`SW_PORTS-1:0] i_cmd_id,
  input  addr_t [`SW_PORTS-1:0]     i_cmd_addr,
  input  logic [`SW_PORTS-1:0]      i_cmd_write,
  input  data_t [`SW_PORTS-1:0]     i_cmd_data,
  output logic [`SW_PORTS-1:0]      o_cmd_accept,

  // Downstream command port.
  output logic                      o_m_cmd_valid,
  output bus_id_t                   o_m_cmd_id,
  output addr_t                     o_m_cmd_addr,
  output logic                      o_m_cmd_write,
  output data_t                     o_m_cmd_data,
  input  logic                      i_m_cmd_accept,

  // Downstream response port.
  input  logic                      i_m_res_valid,
  input  bus_id_t                   i_m_res_id,
  input  data_t                     i_m_res_data,
  output logic                      o_m_res_accept,

  // Upstream response lanes.
  output logic [`SW_PORTS-1:0]      o_res_valid,
  output local_id_t                 o_res_id,
  output data_t                     o_res_data,
  input  logic [`SW_PORTS-1:0]      i_res_accept
);

  switch_request_path switch_request_path_inst (
    .i_clk          (i_clk          ),
    .i_rst          (i_rst          ),
    .i_cmd_valid    (i_cmd_valid    ),
    .i_cmd_id       (i_cmd_id       ),
    .i_cmd_addr     (i_cmd_addr     ),
    .i_cmd_write    (i_cmd_write    ),
    .i_cmd_data     (i_cmd_data     ),
    .o_cmd_accept   (o_cmd_accept   ),
    .o_m_cmd_valid  (o_m_cmd_valid  ),
    .o_m_cmd_id     (o_m_cmd_id     ),
    .o_m_cmd_addr   (o_m_cmd_addr   ),
    .o_m_cmd_write  (o_m_cmd_write  ),
    .o_m_cmd_data   (o_m_cmd_data   ),
    .i_m_cmd_accept (i_m_cmd_accept )
  );

  switch_response_path switch_response_path_inst (
    .i_m_res_valid  (i_m_res_valid  ),
    .i_m_res_id     (i_m_res_id     ),
    .i_m_res_data   (i_m_res_data   ),
    .o_m_res_accept (o_m_res_accept ),
    .o_res_valid    (o_res_valid    ),
    .o_res_id       (o_res_id       ),
    .o_res_data     (o_res_data     ),
    .i_res_accept   (i_res_accept   )
  );

endmodule

/* switch_properties.sv */
/* Concurrent checks of the bus switch: command forwarding, round-robin order,
   back-pressure stability, response routing and idle outputs. */
`include "switch_macros.svh"

module switch_properties
  import switch_pkg::*;
(
  input logic                      i_clk,
  input logic                      i_rst,
  input logic [`SW_PORTS-1:0]      i_cmd_valid, i_cmd_write, o_cmd_accept,
  input local_id_t [`SW_PORTS-1:0] i_cmd_id,
  input addr_t [`SW_PORTS-1:0]     i_cmd_addr,
  input data_t [`SW_PORTS-1:0]     i_cmd_data,
  input logic                      o_m_cmd_valid, o_m_cmd_write, i_m_cmd_accept,
  input bus_id_t                   o_m_cmd_id, i_m_res_id,
  input addr_t                     o_m_cmd_addr,
  input data_t                     o_m_cmd_data, i_m_res_data, o_res_data,
  input logic                      i_m_res_valid, o_m_res_accept,
  input logic [`SW_PORTS-1:0]      o_res_valid, i_res_accept,
  input local_id_t                 o_res_id
);
  int                   error_count = 0; // Polled by the testbench.
  port_idx_t            acc_port;
  port_idx_t            last_port;
  port_idx_t            res_port;
  logic                 contended;
  logic                 cmd_fire;
  logic [`SW_PORTS-1:0] res_onehot;

  task automatic raise_error(input string msg);
    error_count++;
    $error("%s", msg);
  endtask

  assign cmd_fire = o_m_cmd_valid && i_m_cmd_accept;
  assign res_port = i_m_res_id[$bits(bus_id_t)-1-:`SW_SEL_WIDTH];

  always_comb begin
    acc_port = '0;
    for (int p = 0; p < `SW_PORTS; p++) begin
      if (o_cmd_accept[p]) begin
        acc_port = port_idx_t'(p);
      end
    end
  end

  always_comb begin
    res_onehot = '0;
    res_onehot[res_port] = i_m_res_valid;
  end

  // Reset acts as if port 3 was just served, so port 0 comes first.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      last_port <= port_idx_t'(`SW_PORTS - 1);
      contended <= 1'b1;
    end else if (cmd_fire) begin
      last_port <= acc_port;
      contended <= 1'b1;
    end else begin
      contended <= contended && (&i_cmd_valid); // Any gap breaks the strict order.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_fwd_lane: assert property (@(posedge i_clk) disable iff (i_rst)
    (cmd_fire || |o_cmd_accept) |-> cmd_fire && $onehot(o_cmd_accept) && i_cmd_valid[acc_port])
    else raise_error("a downstream transfer was not matched by exactly one valid lane");
  a_fwd_id: assert property (@(posedge i_clk) disable iff (i_rst)
    cmd_fire |-> o_m_cmd_id == {acc_port, i_cmd_id[acc_port]})
    else raise_error($sformatf("mismatch o_m_cmd_id: got %h, expected %h",
      $sampled(o_m_cmd_id), $sampled({acc_port, i_cmd_id[acc_port]})));
  a_fwd_payload: assert property (@(posedge i_clk) disable iff (i_rst)
    cmd_fire |-> {o_m_cmd_addr, o_m_cmd_write, o_m_cmd_data}
      == {i_cmd_addr[acc_port], i_cmd_write[acc_port], i_cmd_data[acc_port]})
    else raise_error($sformatf("mismatch o_m_cmd_addr/write/data: got %h, expected %h",
      $sampled({o_m_cmd_addr, o_m_cmd_write, o_m_cmd_data}),
      $sampled({i_cmd_addr[acc_port], i_cmd_write[acc_port], i_cmd_data[acc_port]})));
  a_round_robin: assert property (@(posedge i_clk) disable iff (i_rst)
    cmd_fire && contended && (&i_cmd_valid) |-> acc_port == port_idx_t'(last_port + 1'b1))
    else raise_error($sformatf("mismatch granted port: got %h, expected %h",
      $sampled(acc_port), $sampled(port_idx_t'(last_port + 1'b1))));
  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_m_cmd_valid && !i_m_cmd_accept |=> o_m_cmd_valid && $stable(o_m_cmd_id)
      && $stable(o_m_cmd_addr) && $stable(o_m_cmd_write) && $stable(o_m_cmd_data))
    else raise_error("the downstream command changed or dropped while stalled");
  a_idle_cmd: assert property (@(posedge i_clk) disable iff (i_rst)
    !(|i_cmd_valid) |-> !o_m_cmd_valid)
    else raise_error("a downstream command appeared with no lane requesting");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_res_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_res_valid == res_onehot)
    else raise_error($sformatf("mismatch o_res_valid: got %h, expected %h",
      $sampled(o_res_valid), $sampled(res_onehot)));
  a_res_payload: assert property (@(posedge i_clk) disable iff (i_rst)
    i_m_res_valid |-> {o_res_id, o_res_data} == {i_m_res_id[`SW_LOCAL_ID_WIDTH-1:0], i_m_res_data})
    else raise_error($sformatf("mismatch o_res_id/o_res_data: got %h/%h, expected %h/%h",
      $sampled(o_res_id), $sampled(o_res_data),
      $sampled(i_m_res_id[`SW_LOCAL_ID_WIDTH-1:0]), $sampled(i_m_res_data)));
  a_res_accept: assert property (@(posedge i_clk) disable iff (i_rst)
    o_m_res_accept == i_res_accept[res_port])
    else raise_error($sformatf("mismatch o_m_res_accept: got %h, expected %h",
      $sampled(o_m_res_accept), $sampled(i_res_accept[res_port])));

endmodule

/* tb_switch_m_to_1.sv */
/* Testbench of the bus switch: clock, reset, random requesters,
   a downstream responder model, watchdog and final verdict. */
`include "switch_macros.svh"

module tb_switch_m_to_1
  import switch_pkg::*;
();
  localparam int N_CMDS     = 2000;
  localparam int CLK_PERIOD = 4;

  logic                      i_clk;
  logic                      i_rst;
  logic [`SW_PORTS-1:0]      i_cmd_valid, i_cmd_write, o_cmd_accept;
  local_id_t [`SW_PORTS-1:0] i_cmd_id;
  addr_t [`SW_PORTS-1:0]     i_cmd_addr;
  data_t [`SW_PORTS-1:0]     i_cmd_data;
  logic                      o_m_cmd_valid, o_m_cmd_write, i_m_cmd_accept;
  bus_id_t                   o_m_cmd_id, i_m_res_id;
  addr_t                     o_m_cmd_addr;
  data_t                     o_m_cmd_data, i_m_res_data, o_res_data;
  logic                      i_m_res_valid, o_m_res_accept;
  logic [`SW_PORTS-1:0]      o_res_valid, i_res_accept;
  local_id_t                 o_res_id;

  bus_id_t              pend_id[$]; // Responses owed by the downstream model.
  data_t                pend_data[$];
  logic [`SW_PORTS-1:0] lane_fire;
  logic                 res_fire;
  int                   n_cmds;
  int                   pick;

  switch_m_to_1 switch_m_to_1_inst (.*);

  bind switch_m_to_1 switch_properties switch_properties_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    wait (switch_m_to_1_inst.switch_properties_inst.error_count != 0);
    $display("*** FAILED ***");
    $fatal(1, "a switch property failed");
  end

  // About 20 cycles per command, far above the random stall rate.
  initial begin
    #(N_CMDS * 20 * CLK_PERIOD);
    $display("*** FAILED ***");
    $fatal(1, "timeout with %0d of %0d commands forwarded", n_cmds, N_CMDS);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and downstream model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    void'($urandom(32'h7acb));
    i_rst          = 1'b1;
    i_cmd_valid    = '0;
    i_cmd_id       = '0;
    i_cmd_addr     = '0;
    i_cmd_write    = '0;
    i_cmd_data     = '0;
    i_m_cmd_accept = 1'b0;
    i_m_res_valid  = 1'b0;
    i_m_res_id     = '0;
    i_m_res_data   = '0;
    i_res_accept   = '0;
    n_cmds         = 0;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    while (n_cmds < N_CMDS) begin
      @(negedge i_clk); // Handshakes are settled, the next edge commits them.
      lane_fire = i_cmd_valid & o_cmd_accept;
      res_fire  = i_m_res_valid && o_m_res_accept;
      if (o_m_cmd_valid && i_m_cmd_accept) begin
        pend_id.push_back(o_m_cmd_id);
        pend_data.push_back(data_t'(o_m_cmd_addr) + data_t'(o_m_cmd_id >> `SW_LOCAL_ID_WIDTH));
        n_cmds++;
      end
      @(posedge i_clk);
      #1;
      for (int p = 0; p < `SW_PORTS; p++) begin
        if (lane_fire[p] || !i_cmd_valid[p]) begin
          i_cmd_valid[p] = ($urandom_range(3) != 0);
          i_cmd_id[p]    = local_id_t'($urandom);
          i_cmd_addr[p]  = addr_t'($urandom);
          i_cmd_write[p] = ($urandom_range(1) != 0);
          i_cmd_data[p]  = data_t'($urandom);
        end
        i_res_accept[p] = ($urandom_range(3) != 0);
      end
      i_m_cmd_accept = ($urandom_range(3) != 0);
      if (res_fire || !i_m_res_valid) begin
        i_m_res_valid = 1'b0;
        if (pend_id.size() != 0 && $urandom_range(3) != 0) begin
          pick          = int'($urandom_range(pend_id.size() - 1)); // Out of order on purpose.
          i_m_res_valid = 1'b1;
          i_m_res_id    = pend_id[pick];
          i_m_res_data  = pend_data[pick];
          pend_id.delete(pick);
          pend_data.delete(pick);
        end
      end
    end
    repeat (2) @(posedge i_clk);
    if (switch_m_to_1_inst.switch_properties_inst.error_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "%0d switch properties failed",
        switch_m_to_1_inst.switch_properties_inst.error_count);
    end
  end

endmodule

/* src.f */
+incdir+.
switch_pkg.sv
switch_rr_arbiter.sv
switch_request_path.sv
switch_response_path.sv
switch_m_to_1.sv
switch_properties.sv
tb_switch_m_to_1.sv
